//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, log to sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f \
		--top-module tb_bulk_in_bridge -Mdir obj_dir
	./obj_dir/Vtb_bulk_in_bridge > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "test: failure reported in sim.log"; exit 1; fi
	@grep -q "Simulation completed successfully" sim.log || \
		(echo "test: run ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+include
rtl/usb_desc_pkg.sv
rtl/bulk_pkg.sv
rtl/config_desc_rom.sv
rtl/telemetry_fifo.sv
rtl/in_source_select.sv
rtl/bulk_in_sequencer.sv
rtl/axis_skid.sv
rtl/bulk_in_bridge.sv
test/tb_bulk_in_bridge.sv

//--- rtl/axis_skid.sv
module axis_skid #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             clock,
  input  logic             areset_n,
  input  logic             s_tvalid_i,
  output logic             s_tready_o,
  input  logic             s_tlast_i,
  input  logic [WIDTH-1:0] s_tdata_i,
  output logic             m_tvalid_o,
  input  logic             m_tready_i,
  output logic             m_tlast_o,
  output logic [WIDTH-1:0] m_tdata_o
);

  logic             skid_valid_q;
  logic             skid_last_q;
  logic [WIDTH-1:0] skid_data_q;
  logic             accept;
  logic             out_free;

  assign s_tready_o = !skid_valid_q;  // registered ready
  assign accept     = s_tvalid_i && s_tready_o;
  assign out_free   = !m_tvalid_o || m_tready_i;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      m_tvalid_o   <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      m_tvalid_o   <= skid_valid_q || accept;
      skid_valid_q <= 1'b0;  // skid drains first
    end else if (accept) begin
      skid_valid_q <= 1'b1;  // park the byte while the output stalls
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      m_tlast_o   <= 1'b0;
      m_tdata_o   <= '0;
      skid_last_q <= 1'b0;
      skid_data_q <= '0;
    end else if (out_free) begin
      if (skid_valid_q) begin
        m_tlast_o <= skid_last_q;
        m_tdata_o <= skid_data_q;
      end else if (accept) begin
        m_tlast_o <= s_tlast_i;
        m_tdata_o <= s_tdata_i;
      end
    end else if (accept) begin
      skid_last_q <= s_tlast_i;
      skid_data_q <= s_tdata_i;
    end
  end

  // upstream holds its byte while the input is stalled
  assert property (@(posedge clock) disable iff (!areset_n)
    (s_tvalid_i && !s_tready_o)
    |=> (s_tvalid_i && $stable(s_tdata_i) && $stable(s_tlast_i)));

endmodule

//--- rtl/bulk_in_bridge.sv
module bulk_in_bridge #(
  parameter int unsigned EP_USER           = 1,
  parameter int unsigned EP_TELE           = 2,
  parameter int unsigned MAX_PACKET        = usb_desc_pkg::MAX_PACKET_HS,
  parameter int unsigned TELE_DEPTH        = 64,
  parameter int unsigned TELE_PACKET_WORDS = 8
) (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 blk_start_i,
  input  bulk_pkg::endpt_t     blk_endpt_i,
  input  logic                 user_ready_i,
  output logic                 blk_nak_o,
  output logic                 blk_done_o,
  input  logic                 s_tvalid_i,
  output logic                 s_tready_o,
  input  logic                 s_tlast_i,
  input  bulk_pkg::data_t      s_tdata_i,
  input  logic                 tel_event_i,
  input  bulk_pkg::tele_word_t tel_word_i,
  output logic                 tx_tvalid_o,
  input  logic                 tx_tready_i,
  output logic                 tx_tlast_o,
  output bulk_pkg::data_t      tx_tdata_o,
  input  logic                 desc_req_i,
  input  logic [15:0]          desc_length_i,
  output logic                 desc_tvalid_o,
  input  logic                 desc_tready_i,
  output logic                 desc_tlast_o,
  output usb_desc_pkg::byte_t  desc_tdata_o
);

  logic            tel_tvalid;
  logic            tel_tready;
  logic            tel_tlast;
  bulk_pkg::data_t tel_tdata;
  logic            tel_packet_ready;

  logic            sel_valid;
  logic            sel_ready;
  logic            src_tvalid;
  logic            src_tready;
  logic            src_tlast;
  bulk_pkg::data_t src_tdata;

  logic            pkt_tvalid;
  logic            pkt_tready;
  logic            pkt_tlast;
  bulk_pkg::data_t pkt_tdata;

  telemetry_fifo #(
    .DEPTH        (TELE_DEPTH),
    .PACKET_WORDS (TELE_PACKET_WORDS)
  ) telemetry_fifo_inst (
    .clock          (clock),
    .areset_n       (areset_n),
    .tel_event_i    (tel_event_i),
    .tel_word_i     (tel_word_i),
    .m_tvalid_o     (tel_tvalid),
    .m_tready_i     (tel_tready),
    .m_tlast_o      (tel_tlast),
    .m_tdata_o      (tel_tdata),
    .packet_ready_o (tel_packet_ready)
  );

  in_source_select #(
    .EP_USER (EP_USER),
    .EP_TELE (EP_TELE)
  ) in_source_select_inst (
    .clock              (clock),
    .areset_n           (areset_n),
    .blk_start_i        (blk_start_i),
    .blk_endpt_i        (blk_endpt_i),
    .user_ready_i       (user_ready_i),
    .s_tvalid_i         (s_tvalid_i),
    .s_tready_o         (s_tready_o),
    .s_tlast_i          (s_tlast_i),
    .s_tdata_i          (s_tdata_i),
    .tel_tvalid_i       (tel_tvalid),
    .tel_tready_o       (tel_tready),
    .tel_tlast_i        (tel_tlast),
    .tel_tdata_i        (tel_tdata),
    .tel_packet_ready_i (tel_packet_ready),
    .sel_valid_o        (sel_valid),
    .sel_ready_o        (sel_ready),
    .src_tvalid_o       (src_tvalid),
    .src_tready_i       (src_tready),
    .src_tlast_o        (src_tlast),
    .src_tdata_o        (src_tdata)
  );

  bulk_in_sequencer #(
    .MAX_PACKET (MAX_PACKET)
  ) bulk_in_sequencer_inst (
    .clock        (clock),
    .areset_n     (areset_n),
    .sel_valid_i  (sel_valid),
    .sel_ready_i  (sel_ready),
    .src_tvalid_i (src_tvalid),
    .src_tready_o (src_tready),
    .src_tlast_i  (src_tlast),
    .src_tdata_i  (src_tdata),
    .pkt_tvalid_o (pkt_tvalid),
    .pkt_tready_i (pkt_tready),
    .pkt_tlast_o  (pkt_tlast),
    .pkt_tdata_o  (pkt_tdata),
    .blk_nak_o    (blk_nak_o),
    .blk_done_o   (blk_done_o)
  );

  axis_skid #(
    .WIDTH (8)
  ) axis_skid_inst (
    .clock      (clock),
    .areset_n   (areset_n),
    .s_tvalid_i (pkt_tvalid),
    .s_tready_o (pkt_tready),
    .s_tlast_i  (pkt_tlast),
    .s_tdata_i  (pkt_tdata),
    .m_tvalid_o (tx_tvalid_o),
    .m_tready_i (tx_tready_i),
    .m_tlast_o  (tx_tlast_o),
    .m_tdata_o  (tx_tdata_o)
  );

  config_desc_rom #(
    .EP_USER    (EP_USER),
    .EP_TELE    (EP_TELE),
    .MAX_PACKET (MAX_PACKET)
  ) config_desc_rom_inst (
    .clock         (clock),
    .areset_n      (areset_n),
    .desc_req_i    (desc_req_i),
    .desc_length_i (desc_length_i),
    .desc_tvalid_o (desc_tvalid_o),
    .desc_tready_i (desc_tready_i),
    .desc_tlast_o  (desc_tlast_o),
    .desc_tdata_o  (desc_tdata_o)
  );

endmodule

//--- rtl/bulk_in_sequencer.sv
module bulk_in_sequencer #(
  parameter int unsigned MAX_PACKET = usb_desc_pkg::MAX_PACKET_HS
) (
  input  logic            clock,
  input  logic            areset_n,
  input  logic            sel_valid_i,
  input  logic            sel_ready_i,
  input  logic            src_tvalid_i,
  output logic            src_tready_o,
  input  logic            src_tlast_i,
  input  bulk_pkg::data_t src_tdata_i,
  output logic            pkt_tvalid_o,
  input  logic            pkt_tready_i,
  output logic            pkt_tlast_o,
  output bulk_pkg::data_t pkt_tdata_o,
  output logic            blk_nak_o,
  output logic            blk_done_o
);

  localparam int CW = $clog2(MAX_PACKET);

  bulk_pkg::seq_state_t state_q;
  logic [CW-1:0] count_q;  // bytes sent in this packet
  logic          sending;
  logic          at_max;
  logic          beat;

  assign sending = (state_q == bulk_pkg::SEQ_SEND);
  assign at_max  = (count_q == CW'(MAX_PACKET - 1));
  assign beat    = pkt_tvalid_o && pkt_tready_i;

  assign pkt_tvalid_o = sending && src_tvalid_i;
  assign src_tready_o = sending && pkt_tready_i;
  assign pkt_tlast_o  = src_tlast_i || at_max;  // cut at max with the rest left in the source
  assign pkt_tdata_o  = src_tdata_i;

  assign blk_nak_o  = (state_q == bulk_pkg::SEQ_DECIDE) && !sel_ready_i;
  assign blk_done_o = (state_q == bulk_pkg::SEQ_DONE);

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q <= bulk_pkg::SEQ_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        bulk_pkg::SEQ_IDLE: begin
          if (sel_valid_i) begin
            state_q <= bulk_pkg::SEQ_DECIDE;
          end
        end
        bulk_pkg::SEQ_DECIDE: begin
          count_q <= '0;
          state_q <= sel_ready_i ? bulk_pkg::SEQ_SEND : bulk_pkg::SEQ_IDLE;
        end
        bulk_pkg::SEQ_SEND: begin
          if (beat) begin
            count_q <= count_q + 1'b1;
            if (pkt_tlast_o) begin
              state_q <= bulk_pkg::SEQ_DONE;
            end
          end
        end
        default: state_q <= bulk_pkg::SEQ_IDLE;  // done pulse lasts one cycle
      endcase
    end
  end

  // tokens from the host side only arrive between transactions
  assert property (@(posedge clock) disable iff (!areset_n)
    sel_valid_i |-> (state_q == bulk_pkg::SEQ_IDLE));

  // the source holds its byte while the packet stream stalls
  assert property (@(posedge clock) disable iff (!areset_n)
    (sending && src_tvalid_i && !src_tready_o)
    |=> (src_tvalid_i && $stable(src_tdata_i) && $stable(src_tlast_i)));

endmodule

//--- rtl/bulk_pkg.sv
package bulk_pkg;

  typedef logic [7:0]  data_t;       // stream byte
  typedef logic [3:0]  endpt_t;      // endpoint number from the token
  typedef logic [31:0] tele_word_t;  // status word

  // one IN transaction
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_DECIDE,  // NAK or go
    SEQ_SEND,
    SEQ_DONE
  } seq_state_t;

  // descriptor reader
  typedef enum logic {
    ROM_IDLE,
    ROM_STREAM
  } rom_state_t;

endpackage

//--- rtl/config_desc_rom.sv
module config_desc_rom #(
  parameter int unsigned EP_USER    = 1,
  parameter int unsigned EP_TELE    = 2,
  parameter int unsigned MAX_PACKET = usb_desc_pkg::MAX_PACKET_HS
) (
  input  logic                clock,
  input  logic                areset_n,
  input  logic                desc_req_i,
  input  logic [15:0]         desc_length_i,
  output logic                desc_tvalid_o,
  input  logic                desc_tready_i,
  output logic                desc_tlast_o,
  output usb_desc_pkg::byte_t desc_tdata_o
);

  localparam int NBYTES = usb_desc_pkg::TOTAL_LEN;
  localparam int IW     = $clog2(NBYTES);

  // byte i of the descriptor sits at bits [8*i +: 8]
  function automatic logic [NBYTES*8-1:0] build_desc();
    logic [NBYTES*8-1:0] d;
    int base;
    d = '0;
    d[0 +: 8]   = 8'(usb_desc_pkg::CONFIG_LEN);
    d[8 +: 8]   = usb_desc_pkg::DESC_CONFIG;
    d[16 +: 16] = 16'(usb_desc_pkg::TOTAL_LEN);  // wTotalLength, low byte first
    d[32 +: 8]  = 8'd1;    // one interface
    d[40 +: 8]  = 8'd1;    // bConfigurationValue
    d[56 +: 8]  = 8'hC0;   // self powered
    d[64 +: 8]  = 8'h32;   // 100 mA
    base = usb_desc_pkg::CONFIG_LEN * 8;
    d[base +: 8]      = 8'(usb_desc_pkg::INTERFACE_LEN);
    d[base + 8 +: 8]  = usb_desc_pkg::DESC_INTERFACE;
    d[base + 32 +: 8] = 8'd2;  // bNumEndpoints, vendor class left at zero
    // user endpoint first, then telemetry
    for (int e = 0; e < 2; e++) begin
      base = (usb_desc_pkg::CONFIG_LEN + usb_desc_pkg::INTERFACE_LEN
              + e * usb_desc_pkg::ENDPOINT_LEN) * 8;
      d[base +: 8]       = 8'(usb_desc_pkg::ENDPOINT_LEN);
      d[base + 8 +: 8]   = usb_desc_pkg::DESC_ENDPOINT;
      d[base + 16 +: 8]  = usb_desc_pkg::DIR_IN | 8'((e == 0) ? EP_USER : EP_TELE);
      d[base + 24 +: 8]  = usb_desc_pkg::ATTR_BULK;
      d[base + 32 +: 16] = 16'(MAX_PACKET);  // wMaxPacketSize
    end
    return d;
  endfunction

  localparam logic [NBYTES*8-1:0] DESC = build_desc();

  bulk_pkg::rom_state_t state_q;
  logic [IW-1:0] idx_q;
  logic [IW-1:0] last_q;  // index of the final byte of this read
  logic [15:0]   len_clip;
  logic          start;

  assign len_clip = (desc_length_i > 16'(NBYTES)) ? 16'(NBYTES) : desc_length_i;
  assign start    = desc_req_i && (desc_length_i != 16'd0) && (state_q == bulk_pkg::ROM_IDLE);

  assign desc_tvalid_o = (state_q == bulk_pkg::ROM_STREAM);
  assign desc_tlast_o  = desc_tvalid_o && (idx_q == last_q);
  assign desc_tdata_o  = DESC[{idx_q, 3'b000} +: 8];

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q <= bulk_pkg::ROM_IDLE;
      idx_q   <= '0;
      last_q  <= '0;
    end else if (start) begin
      state_q <= bulk_pkg::ROM_STREAM;
      idx_q   <= '0;
      last_q  <= IW'(len_clip - 16'd1);
    end else if (desc_tvalid_o && desc_tready_i) begin
      if (desc_tlast_o) begin
        state_q <= bulk_pkg::ROM_IDLE;
      end
      idx_q <= idx_q + 1'b1;
    end
  end

endmodule

//--- rtl/in_source_select.sv
module in_source_select #(
  parameter int unsigned EP_USER = 1,
  parameter int unsigned EP_TELE = 2
) (
  input  logic             clock,
  input  logic             areset_n,
  input  logic             blk_start_i,
  input  bulk_pkg::endpt_t blk_endpt_i,
  input  logic             user_ready_i,
  input  logic             s_tvalid_i,
  output logic             s_tready_o,
  input  logic             s_tlast_i,
  input  bulk_pkg::data_t  s_tdata_i,
  input  logic             tel_tvalid_i,
  output logic             tel_tready_o,
  input  logic             tel_tlast_i,
  input  bulk_pkg::data_t  tel_tdata_i,
  input  logic             tel_packet_ready_i,
  output logic             sel_valid_o,
  output logic             sel_ready_o,
  output logic             src_tvalid_o,
  input  logic             src_tready_i,
  output logic             src_tlast_o,
  output bulk_pkg::data_t  src_tdata_o
);

  bulk_pkg::endpt_t endpt_q;
  logic user_sel;
  logic tele_sel;

  assign user_sel = (endpt_q == 4'(EP_USER));
  assign tele_sel = (endpt_q == 4'(EP_TELE));

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      endpt_q     <= '0;
      sel_valid_o <= 1'b0;
      sel_ready_o <= 1'b0;
    end else begin
      sel_valid_o <= blk_start_i;
      if (blk_start_i) begin
        endpt_q     <= blk_endpt_i;
        sel_ready_o <= ((blk_endpt_i == 4'(EP_USER)) && user_ready_i)
                       || ((blk_endpt_i == 4'(EP_TELE)) && tel_packet_ready_i);
      end
    end
  end

  assign src_tvalid_o = user_sel ? s_tvalid_i : (tele_sel && tel_tvalid_i);
  assign src_tlast_o  = user_sel ? s_tlast_i : tel_tlast_i;
  assign src_tdata_o  = user_sel ? s_tdata_i : tel_tdata_i;
  assign s_tready_o   = user_sel && src_tready_i;  // only the latched source sees ready
  assign tel_tready_o = tele_sel && src_tready_i;

endmodule

//--- rtl/telemetry_fifo.sv
module telemetry_fifo #(
  parameter int unsigned DEPTH        = 64,  // words as a power of two
  parameter int unsigned PACKET_WORDS = 8
) (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 tel_event_i,
  input  bulk_pkg::tele_word_t tel_word_i,
  output logic                 m_tvalid_o,
  input  logic                 m_tready_i,
  output logic                 m_tlast_o,
  output bulk_pkg::data_t      m_tdata_o,
  output logic                 packet_ready_o
);

  localparam int AW  = $clog2(DEPTH);
  localparam int LW  = $clog2(DEPTH + 1);
  localparam int WCW = (PACKET_WORDS > 1) ? $clog2(PACKET_WORDS) : 1;

  bulk_pkg::tele_word_t mem [DEPTH];

  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [LW-1:0]  level_q;
  logic [1:0]     byte_cnt_q;  // byte within the word from the low end
  logic [WCW-1:0] word_cnt_q;  // word within the packet
  logic           full;
  logic           push;
  logic           pop;
  logic           beat;
  logic           last_word;

  assign full      = (level_q == LW'(DEPTH));
  assign push      = tel_event_i && !full;  // dropped when full
  assign beat      = m_tvalid_o && m_tready_i;
  assign pop       = beat && (byte_cnt_q == 2'd3);
  assign last_word = (word_cnt_q == WCW'(PACKET_WORDS - 1));

  assign m_tvalid_o = (level_q != '0);
  assign m_tdata_o  = mem[rd_ptr_q][{byte_cnt_q, 3'b000} +: 8];
  assign m_tlast_o  = (byte_cnt_q == 2'd3) && last_word;

  // a packet already begun is finished even once the level drops below a packet
  assign packet_ready_o = (level_q >= LW'(PACKET_WORDS)) || (word_cnt_q != '0)
                          || (byte_cnt_q != 2'd0);

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr_q] <= tel_word_i;
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      byte_cnt_q <= 2'd0;
      word_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (beat) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q   <= rd_ptr_q + 1'b1;
        word_cnt_q <= last_word ? '0 : word_cnt_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // level agrees with the distance between the pointers
  assert property (@(posedge clock) disable iff (!areset_n)
    level_q[AW-1:0] == AW'(wr_ptr_q - rd_ptr_q));

  // reads start only on a whole packet so none runs dry halfway
  assert property (@(posedge clock) disable iff (!areset_n)
    ((word_cnt_q != '0) || (byte_cnt_q != 2'd0)) |-> (level_q != '0));

endmodule

//--- rtl/usb_desc_pkg.sv
package usb_desc_pkg;

  typedef logic [7:0] byte_t;  // one descriptor byte

  // bDescriptorType codes
  localparam byte_t DESC_CONFIG    = 8'd2;
  localparam byte_t DESC_INTERFACE = 8'd4;
  localparam byte_t DESC_ENDPOINT  = 8'd5;

  // bLength of each descriptor
  localparam int CONFIG_LEN    = 9;
  localparam int INTERFACE_LEN = 9;
  localparam int ENDPOINT_LEN  = 7;

  // config + interface + two IN endpoints, also wTotalLength
  localparam int TOTAL_LEN = 32;

  // endpoint descriptor fields
  localparam byte_t ATTR_BULK = 8'd2;    // bmAttributes transfer type
  localparam byte_t DIR_IN    = 8'h80;   // direction bit of bEndpointAddress

  // high-speed bulk packets are 512 bytes
  localparam int MAX_PACKET_HS = 512;

endpackage

//--- include/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  checks++;
  if (expected !== actual) begin
    errors++;
    $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expected, actual);
  end
endtask

task automatic note_failure(input string what);
  errors++;
  $display("ERROR at %0t: %s", $time, what);
endtask

task automatic end_test(input string name, input int errors_before);
  if (errors == errors_before) begin
    $display("test %s: pass", name);
  end else begin
    tests_failed++;
    $display("test %s: FAIL with %0d errors", name, errors - errors_before);
  end
endtask

// one-cycle token, start_cycle is the cycle count when it was driven
task automatic start_token(input int endpt, output int start_cycle);
  @(negedge clock);
  blk_start_i = 1'b1;
  blk_endpt_i = 4'(endpt);
  start_cycle = cycle;
  @(negedge clock);
  blk_start_i = 1'b0;
endtask

task automatic load_user_packet(input int count);
  int i;
  logic [7:0] b;
  for (i = 0; i < count; i++) begin
    b = 8'($urandom);
    user_bytes.push_back(b);
    user_lasts.push_back(i == count - 1);
    exp_bytes.push_back(b);
  end
endtask

task automatic push_telemetry(input int words);
  int i;
  int b;
  logic [31:0] w;
  for (i = 0; i < words; i++) begin
    @(negedge clock);
    w = $urandom;
    tel_event_i = 1'b1;
    tel_word_i  = w;
    for (b = 0; b < 4; b++) begin
      exp_bytes.push_back(w[8*b +: 8]);  // low byte leaves first
    end
  end
  @(negedge clock);
  tel_event_i = 1'b0;
endtask

// token, then the packet must match the next count expected bytes
task automatic collect_packet(input int endpt, input int count);
  int start_cycle;
  int waited;
  int i;
  logic [7:0] want;
  tx_bytes.delete();
  tx_lasts.delete();
  nak_cycles.delete();
  done_count = 0;
  start_token(endpt, start_cycle);
  waited = 0;
  while ((done_count == 0 || tx_bytes.size() < count) && waited < 400) begin
    @(negedge clock);
    waited++;
  end
  if (done_count == 0) begin
    note_failure($sformatf("no blk_done_o after token on endpoint %0d", endpt));
  end
  check_value("tx byte count", 32'(count), 32'(tx_bytes.size()));
  for (i = 0; i < count; i++) begin
    want = exp_bytes.pop_front();
    if (i < tx_bytes.size()) begin
      check_value("tx_tdata_o", 32'(want), 32'(tx_bytes[i]));
      check_value("tx_tlast_o", 32'(i == count - 1), 32'(tx_lasts[i]));
    end
  end
  check_value("blk_done_o pulses", 32'd1, 32'(done_count));
  check_value("blk_nak_o pulses", 32'd0, 32'(nak_cycles.size()));
endtask

task automatic read_descriptor(input int length);
  int expect_n;
  int got;
  int waited;
  logic finished;
  expect_n = (length < 32) ? length : 32;
  @(negedge clock);
  desc_req_i    = 1'b1;
  desc_length_i = 16'(length);
  @(negedge clock);
  desc_req_i = 1'b0;
  got      = 0;
  waited   = 0;
  finished = 1'b0;
  while (!finished && waited < 200) begin
    desc_tready_i = ($urandom % 4) != 0;  // stalls must hold the byte
    if (desc_tvalid_o && desc_tready_i) begin
      if (got < 32) begin
        check_value("desc_tdata_o", 32'(DESC_BYTES[got]), 32'(desc_tdata_o));
      end
      check_value("desc_tlast_o", 32'(got == expect_n - 1), 32'(desc_tlast_o));
      finished = desc_tlast_o || (got >= 40);
      got++;
    end
    @(negedge clock);
    waited++;
  end
  desc_tready_i = 1'b1;
  check_value("desc byte count", 32'(expect_n), 32'(got));
  check_value("desc_tvalid_o", 32'd0, 32'(desc_tvalid_o));
endtask

task automatic expect_nak(input int endpt);
  int start_cycle;
  int waited;
  nak_cycles.delete();
  start_token(endpt, start_cycle);
  waited = 0;
  while (nak_cycles.size() == 0 && waited < 8) begin
    @(negedge clock);
    waited++;
  end
  if (nak_cycles.size() == 0) begin
    note_failure($sformatf("no NAK for token on endpoint %0d", endpt));
  end else begin
    check_value("blk_nak_o delay", 32'd2, 32'(nak_cycles[0] - start_cycle));
  end
endtask

task automatic test_descriptor_reads();
  int e0;
  e0 = errors;
  check_value("blk_nak_o", 32'd0, 32'(blk_nak_o));  // state right after reset
  check_value("blk_done_o", 32'd0, 32'(blk_done_o));
  check_value("tx_tvalid_o", 32'd0, 32'(tx_tvalid_o));
  check_value("desc_tvalid_o", 32'd0, 32'(desc_tvalid_o));
  check_value("s_tready_o", 32'd0, 32'(s_tready_o));
  read_descriptor(9);
  read_descriptor(32);
  read_descriptor(64);
  end_test("descriptor reads", e0);
endtask

task automatic test_nak();
  int e0;
  e0 = errors;
  user_ready_i = 1'b0;
  tx_bytes.delete();
  done_count = 0;
  expect_nak(EP_USER);
  expect_nak(EP_TELE);  // fifo still empty
  expect_nak(5);
  check_value("tx byte count", 32'd0, 32'(tx_bytes.size()));
  check_value("blk_done_o pulses", 32'd0, 32'(done_count));
  end_test("nak", e0);
endtask

task automatic test_short_user_packet();
  int e0;
  e0 = errors;
  user_ready_i = 1'b1;
  load_user_packet(10);
  collect_packet(EP_USER, 10);
  end_test("short user packet", e0);
endtask

task automatic test_packet_cut();
  int e0;
  e0 = errors;
  load_user_packet(40);
  collect_packet(EP_USER, 16);
  collect_packet(EP_USER, 16);
  collect_packet(EP_USER, 8);
  end_test("packet cut at max size", e0);
endtask

task automatic test_telemetry_backpressure();
  int e0;
  e0 = errors;
  rand_ready = 1'b1;
  push_telemetry(8);
  collect_packet(EP_TELE, 16);  // capped at MAX_PACKET
  collect_packet(EP_TELE, 16);
  rand_ready = 1'b0;
  end_test("telemetry with back-pressure", e0);
endtask

`endif

//--- test/tb_bulk_in_bridge.sv
module tb_bulk_in_bridge;

  localparam int EP_USER     = 1;
  localparam int EP_TELE     = 2;
  localparam int MAX_PACKET  = 16;
  localparam int TELE_DEPTH  = 16;
  localparam int CYCLE_LIMIT = 20000;  // tests need about 600 cycles

  // configuration, interface, user endpoint, telemetry endpoint
  localparam logic [7:0] DESC_BYTES [32] = '{
    8'h09, 8'h02, 8'h20, 8'h00, 8'h01, 8'h01, 8'h00, 8'hC0, 8'h32,
    8'h09, 8'h04, 8'h00, 8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'h00,
    8'h07, 8'h05, 8'h80 | 8'(EP_USER), 8'h02,
    8'(MAX_PACKET % 256), 8'(MAX_PACKET / 256), 8'h00,
    8'h07, 8'h05, 8'h80 | 8'(EP_TELE), 8'h02,
    8'(MAX_PACKET % 256), 8'(MAX_PACKET / 256), 8'h00
  };

  logic        clock;
  logic        areset_n;
  logic        blk_start_i;
  logic [3:0]  blk_endpt_i;
  logic        user_ready_i;
  logic        blk_nak_o;
  logic        blk_done_o;
  logic        s_tvalid_i;
  logic        s_tready_o;
  logic        s_tlast_i;
  logic [7:0]  s_tdata_i;
  logic        tel_event_i;
  logic [31:0] tel_word_i;
  logic        tx_tvalid_o;
  logic        tx_tready_i;
  logic        tx_tlast_o;
  logic [7:0]  tx_tdata_o;
  logic        desc_req_i;
  logic [15:0] desc_length_i;
  logic        desc_tvalid_o;
  logic        desc_tready_i;
  logic        desc_tlast_o;
  logic [7:0]  desc_tdata_o;

  logic [7:0] tx_bytes [$];    // captured ahead of each transmit transfer
  logic       tx_lasts [$];
  int         nak_cycles [$];
  int         done_count;
  logic [7:0] user_bytes [$];  // user source, still to be sent
  logic       user_lasts [$];
  logic [7:0] exp_bytes [$];   // expected transmit order
  logic       rand_ready;      // random tx_tready_i gaps
  int         cycle;
  int         checks;
  int         errors;
  int         tests_failed;

  bulk_in_bridge #(
    .EP_USER    (EP_USER),
    .EP_TELE    (EP_TELE),
    .MAX_PACKET (MAX_PACKET),
    .TELE_DEPTH (TELE_DEPTH)
  ) bulk_in_bridge_inst (
    .clock (clock), .areset_n (areset_n),
    .blk_start_i (blk_start_i), .blk_endpt_i (blk_endpt_i),
    .user_ready_i (user_ready_i), .blk_nak_o (blk_nak_o), .blk_done_o (blk_done_o),
    .s_tvalid_i (s_tvalid_i), .s_tready_o (s_tready_o),
    .s_tlast_i (s_tlast_i), .s_tdata_i (s_tdata_i),
    .tel_event_i (tel_event_i), .tel_word_i (tel_word_i),
    .tx_tvalid_o (tx_tvalid_o), .tx_tready_i (tx_tready_i),
    .tx_tlast_o (tx_tlast_o), .tx_tdata_o (tx_tdata_o),
    .desc_req_i (desc_req_i), .desc_length_i (desc_length_i),
    .desc_tvalid_o (desc_tvalid_o), .desc_tready_i (desc_tready_i),
    .desc_tlast_o (desc_tlast_o), .desc_tdata_o (desc_tdata_o)
  );

  `include "tb_tasks.svh"

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    cycle = 0;
    while (cycle < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle++;
    end
    $display("timeout: no result after %0d cycles, a handshake never completed", CYCLE_LIMIT);
    $display("Simulation failed");
    $finish;
  end

  // user source, transmit sink and pulse monitor, all on the falling edge
  initial begin
    s_tvalid_i  = 1'b0;
    s_tlast_i   = 1'b0;
    s_tdata_i   = 8'h00;
    tx_tready_i = 1'b1;
    forever begin
      @(negedge clock);
      if (user_bytes.size() > 0) begin
        s_tvalid_i = 1'b1;  // head byte held until it transfers
        s_tdata_i  = user_bytes[0];
        s_tlast_i  = user_lasts[0];
        if (s_tready_o) begin
          void'(user_bytes.pop_front());
          void'(user_lasts.pop_front());
        end
      end else begin
        s_tvalid_i = 1'b0;
      end
      tx_tready_i = rand_ready ? (($urandom % 4) != 0) : 1'b1;
      if (tx_tvalid_o && tx_tready_i) begin
        tx_bytes.push_back(tx_tdata_o);
        tx_lasts.push_back(tx_tlast_o);
      end
      if (blk_nak_o) nak_cycles.push_back(cycle);
      if (blk_done_o) done_count++;
    end
  end

  initial begin
    void'($urandom(32'h7c96_ed25));
    areset_n      = 1'b0;
    blk_start_i   = 1'b0;
    blk_endpt_i   = 4'd0;
    user_ready_i  = 1'b0;
    tel_event_i   = 1'b0;
    tel_word_i    = 32'd0;
    desc_req_i    = 1'b0;
    desc_length_i = 16'd0;
    desc_tready_i = 1'b1;
    rand_ready    = 1'b0;
    done_count    = 0;
    checks        = 0;
    errors        = 0;
    tests_failed  = 0;
    repeat (16) @(negedge clock);
    areset_n = 1'b1;
    test_descriptor_reads();
    test_nak();
    test_short_user_packet();
    test_packet_cut();
    test_telemetry_backpressure();
    $display("summary: 5 tests, %0d failed, %0d checks, %0d errors",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
